/* im2col_pkg.sv */
/*
 * im2col smart peripheral controller package
 * Sizes, DMA register map, element types and the packed structs shared
 * by the dispatch core.
 */

package im2col_pkg;

  localparam int unsigned DMA_CH_NUM = 4;
  localparam int unsigned CH_IDX_W   = (DMA_CH_NUM > 1) ? $clog2(DMA_CH_NUM) : 1;
  localparam int unsigned FIFO_DEPTH = 4;  // Power of two

  localparam logic [31:0] DMA_BASE_ADDR = 32'h0003_0000;
  localparam logic [31:0] DMA_CH_SIZE   = 32'h0000_0100;  // Register window per channel

  // Each value is the register's byte offset inside a channel window
  typedef enum logic [7:0] {
    DMA_SRC_PTR    = 8'h00,
    DMA_DST_PTR    = 8'h04,
    DMA_SIZE_D1    = 8'h0C,
    DMA_SIZE_D2    = 8'h10,
    DMA_SRC_INC_D1 = 8'h18,
    DMA_SRC_INC_D2 = 8'h1C,
    DMA_DST_INC_D1 = 8'h20,
    DMA_DST_INC_D2 = 8'h24,
    DMA_SLOTS      = 8'h28,
    DMA_SRC_TYPE   = 8'h2C,
    DMA_DST_TYPE   = 8'h30,
    DMA_DIM        = 8'h3C,
    DMA_TOP_PAD    = 8'h44,
    DMA_BOTTOM_PAD = 8'h48,
    DMA_RIGHT_PAD  = 8'h4C,
    DMA_LEFT_PAD   = 8'h50
  } dma_reg_e;

  // Element size, byte shift is 2 - value
  typedef enum logic [1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2
  } data_type_e;

  typedef struct packed {
    data_type_e            data_type;
    logic [3:0]            log_stride_d1;
    logic [31:0]           slots;          // Trigger slot word
    logic [DMA_CH_NUM-1:0] ch_mask;        // Enabled channels
    logic                  irq_en;
  } im2col_cfg_t;

  typedef struct packed {
    logic [31:0] in_ptr;
    logic [31:0] out_ptr;
    logic [7:0]  pad_top;
    logic [7:0]  pad_bottom;
    logic [7:0]  pad_left;
    logic [7:0]  pad_right;
    logic [22:0] src_inc_d2;
    logic [15:0] size_d1;
    logic [15:0] size_d2;
    logic        last;                     // Closes the batch
  } im2col_txn_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dma_reg_req_t;

endpackage

/* im2col_txn_fifo.sv */
/*
 * Transaction queue
 * Fall-through circular buffer between the host and the dispatcher,
 * the head entry is visible while the queue is not empty.
 */

`timescale 1ns/1ps

module im2col_txn_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  im2col_pkg::im2col_txn_t data_i,
  input  logic                    pop_i,
  output im2col_pkg::im2col_txn_t data_o,
  output logic                    empty_o,
  output logic                    full_o
);

  import im2col_pkg::*;

  im2col_txn_t                   mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(FIFO_DEPTH):0]   count_q;
  logic                          do_push;
  logic                          do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == ($clog2(FIFO_DEPTH) + 1)'(FIFO_DEPTH));
  assign do_push = push_i & ~full_o;   // Push while full is dropped
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* im2col_channel_tracker.sv */
/*
 * DMA channel tracker
 * Keeps the occupied and first-write bits of every channel and finds the
 * lowest enabled channel that is free.
 */

`timescale 1ns/1ps

module im2col_channel_tracker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [im2col_pkg::DMA_CH_NUM-1:0] ch_mask_i,
  input  logic                              claim_i,
  input  logic [im2col_pkg::DMA_CH_NUM-1:0] dma_done_i,
  input  logic                              batch_done_i,
  output logic                              free_o,
  output logic [im2col_pkg::CH_IDX_W-1:0]   free_ch_o,
  output logic                              first_write_o,
  output logic                              any_busy_o
);

  import im2col_pkg::*;

  logic [DMA_CH_NUM-1:0] occupied_q;
  logic [DMA_CH_NUM-1:0] first_write_q;
  logic [CH_IDX_W-1:0]   pick_ch;
  logic [CH_IDX_W-1:0]   ch_q;

  // Priority search, walking down so the lowest index wins
  always_comb begin
    free_o  = 1'b0;
    pick_ch = '0;
    for (int i = DMA_CH_NUM - 1; i >= 0; i--) begin
      if (ch_mask_i[i] && !occupied_q[i]) begin
        free_o  = 1'b1;
        pick_ch = CH_IDX_W'(i);
      end
    end
  end

  assign first_write_o = first_write_q[pick_ch];  // Bit of the channel about to be claimed
  assign free_ch_o     = ch_q;                    // Channel being programmed
  assign any_busy_o    = |occupied_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q    <= '0;
      first_write_q <= '0;
      ch_q          <= '0;
    end else begin
      if (batch_done_i) begin
        first_write_q <= '0;  // Next batch reloads the full register set
      end
      occupied_q <= occupied_q & ~dma_done_i;
      if (claim_i) begin
        ch_q                   <= pick_ch;
        occupied_q[pick_ch]    <= 1'b1;
        first_write_q[pick_ch] <= 1'b1;
      end
    end
  end

endmodule

/* im2col_dma_loader.sv */
/*
 * DMA register loader
 * Turns the head transaction into the ordered register writes of one DMA
 * channel, scaling the fields by the element size.
 */

`timescale 1ns/1ps

module im2col_dma_loader (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  im2col_pkg::im2col_cfg_t         cfg_i,
  input  im2col_pkg::im2col_txn_t         txn_i,
  input  logic                            txn_empty_i,
  input  logic                            free_i,
  input  logic [im2col_pkg::CH_IDX_W-1:0] free_ch_i,
  input  logic                            first_write_i,
  input  logic                            batch_done_i,
  input  logic                            bus_ready_i,
  output logic                            claim_o,
  output logic                            pop_o,
  output logic                            last_loaded_o,
  output im2col_pkg::dma_reg_req_t        bus_req_o
);

  import im2col_pkg::*;

  typedef enum logic {
    LD_IDLE,
    LD_WRITE
  } ld_state_e;

  ld_state_e   state_q;
  dma_reg_e    step_q;
  logic        loaded_q;
  logic        wr_done;
  logic [1:0]  elem_shift;
  logic [7:0]  pad;
  logic [31:0] wdata;

  function automatic dma_reg_e next_step(dma_reg_e s);
    case (s)
      DMA_DIM:        next_step = DMA_SLOTS;
      DMA_SLOTS:      next_step = DMA_SRC_TYPE;
      DMA_SRC_TYPE:   next_step = DMA_DST_TYPE;
      DMA_DST_TYPE:   next_step = DMA_TOP_PAD;
      DMA_TOP_PAD:    next_step = DMA_BOTTOM_PAD;
      DMA_BOTTOM_PAD: next_step = DMA_LEFT_PAD;
      DMA_LEFT_PAD:   next_step = DMA_RIGHT_PAD;
      DMA_RIGHT_PAD:  next_step = DMA_SRC_PTR;
      DMA_SRC_PTR:    next_step = DMA_DST_PTR;
      DMA_DST_PTR:    next_step = DMA_SRC_INC_D1;
      DMA_SRC_INC_D1: next_step = DMA_SRC_INC_D2;
      DMA_SRC_INC_D2: next_step = DMA_DST_INC_D1;
      DMA_DST_INC_D1: next_step = DMA_DST_INC_D2;
      DMA_DST_INC_D2: next_step = DMA_SIZE_D2;
      DMA_SIZE_D2:    next_step = DMA_SIZE_D1;
      default:        next_step = DMA_SIZE_D1;  // Size d1 is the final write
    endcase
  endfunction

  assign claim_o       = (state_q == LD_IDLE) && !txn_empty_i && free_i && !loaded_q;
  assign wr_done       = (state_q == LD_WRITE) && bus_ready_i;
  assign pop_o         = wr_done && (step_q == DMA_SIZE_D1);
  assign last_loaded_o = pop_o && txn_i.last;
  assign elem_shift    = 2'd2 - cfg_i.data_type;

  always_comb begin
    case (step_q)
      DMA_TOP_PAD:    pad = txn_i.pad_top;
      DMA_BOTTOM_PAD: pad = txn_i.pad_bottom;
      DMA_LEFT_PAD:   pad = txn_i.pad_left;
      default:        pad = txn_i.pad_right;
    endcase
  end

  always_comb begin
    case (step_q)
      DMA_DIM:        wdata = 32'h1;  // 2D transfers
      DMA_SLOTS:      wdata = cfg_i.slots;
      DMA_SRC_TYPE,
      DMA_DST_TYPE:   wdata = {30'h0, cfg_i.data_type};
      DMA_TOP_PAD,
      DMA_BOTTOM_PAD,
      DMA_LEFT_PAD,
      DMA_RIGHT_PAD:  wdata = ({24'h0, pad} << elem_shift) & 32'h3F;
      DMA_SRC_PTR:    wdata = txn_i.in_ptr;
      DMA_DST_PTR:    wdata = txn_i.out_ptr;
      DMA_SRC_INC_D1: wdata = ((32'h1 << cfg_i.log_stride_d1) << elem_shift) & 32'h3F;
      DMA_SRC_INC_D2: wdata = ({9'h0, txn_i.src_inc_d2} << elem_shift) & 32'h7F_FFFF;
      DMA_DST_INC_D1,
      DMA_DST_INC_D2: wdata = 32'h4 >> cfg_i.data_type;  // One element, dense output
      DMA_SIZE_D2:    wdata = ({16'h0, txn_i.size_d2} << elem_shift) & 32'hFFFF;
      DMA_SIZE_D1:    wdata = ({16'h0, txn_i.size_d1} << elem_shift) & 32'hFFFF;
      default:        wdata = '0;
    endcase
  end

  // Request is held stable by the state until the handshake
  assign bus_req_o.valid = (state_q == LD_WRITE);
  assign bus_req_o.addr  = DMA_BASE_ADDR + 32'(free_ch_i) * DMA_CH_SIZE + {24'h0, step_q};
  assign bus_req_o.wdata = wdata;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= LD_IDLE;
      step_q   <= DMA_DIM;
      loaded_q <= 1'b0;
    end else begin
      if (batch_done_i) begin
        loaded_q <= 1'b0;
      end else if (last_loaded_o) begin
        loaded_q <= 1'b1;  // Hold off until the batch drains
      end
      case (state_q)
        LD_IDLE: begin
          if (claim_o) begin
            state_q <= LD_WRITE;
            step_q  <= first_write_i ? DMA_TOP_PAD : DMA_DIM;  // Skip setup on reuse
          end
        end
        default: begin
          if (pop_o) begin
            state_q <= LD_IDLE;
          end else if (wr_done) begin
            step_q <= next_step(step_q);
          end
        end
      endcase
    end
  end

endmodule

/* im2col_completion.sv */
/*
 * Batch completion
 * Detects the end of a batch, keeps the busy status and the sticky
 * interrupt flag.
 */

`timescale 1ns/1ps

module im2col_completion (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic last_loaded_i,
  input  logic any_busy_i,
  input  logic irq_en_i,
  input  logic irq_clear_i,
  output logic batch_done_o,
  output logic busy_o,
  output logic irq_o
);

  logic loaded_q;
  logic done_q;
  logic busy_q;
  logic irq_q;
  logic batch_end;

  // All transactions loaded and every channel released
  assign batch_end = loaded_q & ~any_busy_i;

  assign batch_done_o = done_q;
  assign busy_o       = busy_q;
  assign irq_o        = irq_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      done_q   <= 1'b0;
      busy_q   <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      done_q <= batch_end;  // Single pulse since loaded_q clears
      if (batch_end) begin
        loaded_q <= 1'b0;
      end else if (last_loaded_i) begin
        loaded_q <= 1'b1;
      end
      if (batch_end) begin
        busy_q <= 1'b0;
      end else if (start_i) begin
        busy_q <= 1'b1;
      end
      if (batch_end && irq_en_i) begin
        irq_q <= 1'b1;
      end else if (irq_clear_i) begin
        irq_q <= 1'b0;  // Host acknowledge
      end
    end
  end

endmodule

/* im2col_spc_top.sv */
/*
 * im2col smart peripheral controller, dispatch core
 * Queue, channel tracker, DMA register loader and batch completion.
 */

`timescale 1ns/1ps

module im2col_spc_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  im2col_pkg::im2col_cfg_t           cfg_i,
  input  logic                              start_i,
  input  im2col_pkg::im2col_txn_t           txn_i,
  input  logic                              txn_push_i,
  input  logic                              bus_ready_i,
  input  logic [im2col_pkg::DMA_CH_NUM-1:0] dma_done_i,
  input  logic                              irq_clear_i,
  output logic                              txn_full_o,
  output im2col_pkg::dma_reg_req_t          bus_req_o,
  output logic                              busy_o,
  output logic                              irq_o
);

  import im2col_pkg::*;

  im2col_txn_t         head_txn;
  logic                txn_empty;
  logic                txn_pop;
  logic                ch_free;
  logic [CH_IDX_W-1:0] ch_idx;
  logic                ch_first_write;
  logic                ch_claim;
  logic                any_busy;
  logic                last_loaded;
  logic                batch_done;

  im2col_txn_fifo u_txn_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (txn_push_i),
    .data_i  (txn_i),
    .pop_i   (txn_pop),
    .data_o  (head_txn),
    .empty_o (txn_empty),
    .full_o  (txn_full_o)
  );

  im2col_channel_tracker u_channel_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ch_mask_i     (cfg_i.ch_mask),
    .claim_i       (ch_claim),
    .dma_done_i    (dma_done_i),
    .batch_done_i  (batch_done),
    .free_o        (ch_free),
    .free_ch_o     (ch_idx),
    .first_write_o (ch_first_write),
    .any_busy_o    (any_busy)
  );

  im2col_dma_loader u_dma_loader (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg_i),
    .txn_i         (head_txn),
    .txn_empty_i   (txn_empty),
    .free_i        (ch_free),
    .free_ch_i     (ch_idx),
    .first_write_i (ch_first_write),
    .batch_done_i  (batch_done),
    .bus_ready_i   (bus_ready_i),
    .claim_o       (ch_claim),
    .pop_o         (txn_pop),
    .last_loaded_o (last_loaded),
    .bus_req_o     (bus_req_o)
  );

  im2col_completion u_completion (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .last_loaded_i (last_loaded),
    .any_busy_i    (any_busy),
    .irq_en_i      (cfg_i.irq_en),
    .irq_clear_i   (irq_clear_i),
    .batch_done_o  (batch_done),
    .busy_o        (busy_o),
    .irq_o         (irq_o)
  );

endmodule

/* tb_im2col_spc.sv */
/*
 * Testbench for the im2col dispatch core
 * Random batches of transactions with bus stalls and DMA completions,
 * checked write by write against a reference model.
 */

`timescale 1ns/1ps

module tb_im2col_spc;

  import im2col_pkg::*;

  localparam int N_BATCH      = 6;
  localparam int MAX_TXN      = 6;   // Transactions per batch
  localparam int MAX_STALL    = 3;   // Consecutive ready-low cycles
  localparam int MAX_DONE_DLY = 8;
  localparam int TIMEOUT_CYC  = 2 * (N_BATCH * MAX_TXN * 16 * (MAX_STALL + 1)
                                     + N_BATCH * (MAX_TXN * (MAX_DONE_DLY + 2) + 40));

  logic                  clk = 1'b0;
  logic                  rst_n;
  im2col_cfg_t           cfg;
  logic                  start;
  im2col_txn_t           txn;
  logic                  txn_push;
  logic                  bus_ready;
  logic [DMA_CH_NUM-1:0] dma_done;
  logic                  irq_clear;
  logic                  txn_full;
  dma_reg_req_t          bus_req;
  logic                  busy;
  logic                  irq;

  integer                seed;
  im2col_txn_t           exp_q [$];     // Pushed but not yet programmed
  im2col_txn_t           cur_txn;
  int                    cur_ch;
  int                    step;
  logic                  in_txn;
  logic [DMA_CH_NUM-1:0] occ;           // Model of occupied channels
  logic [DMA_CH_NUM-1:0] used;          // Channels already programmed this batch
  logic [DMA_CH_NUM-1:0] done_prev;
  int                    done_cnt [DMA_CH_NUM];
  logic                  loaded;
  logic                  loaded_pend;
  int                    stall_cnt;
  logic                  prev_stall;
  dma_reg_req_t          prev_req;

  always #4 clk = ~clk;

  im2col_spc_top UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cfg_i       (cfg),
    .start_i     (start),
    .txn_i       (txn),
    .txn_push_i  (txn_push),
    .bus_ready_i (bus_ready),
    .dma_done_i  (dma_done),
    .irq_clear_i (irq_clear),
    .txn_full_o  (txn_full),
    .bus_req_o   (bus_req),
    .busy_o      (busy),
    .irq_o       (irq)
  );

  task automatic report_error(string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_req(dma_reg_req_t got, dma_reg_req_t exp, string what);
    if (got !== exp) begin
      report_error($sformatf("%s: got %0b/%08h/%08h, expected %0b/%08h/%08h", what,
                             got.valid, got.addr, got.wdata, exp.valid, exp.addr, exp.wdata));
    end
  endtask

  task automatic check_type(data_type_e got, data_type_e exp, string what);
    if (got !== exp) begin
      report_error($sformatf("%s: got type %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      report_error($sformatf("%s: got %b, expected %b", what, got, exp));
    end
  endtask

  // Write order of a full channel setup
  function automatic dma_reg_e step_reg(int idx);
    case (idx)
      0:       step_reg = DMA_DIM;
      1:       step_reg = DMA_SLOTS;
      2:       step_reg = DMA_SRC_TYPE;
      3:       step_reg = DMA_DST_TYPE;
      4:       step_reg = DMA_TOP_PAD;
      5:       step_reg = DMA_BOTTOM_PAD;
      6:       step_reg = DMA_LEFT_PAD;
      7:       step_reg = DMA_RIGHT_PAD;
      8:       step_reg = DMA_SRC_PTR;
      9:       step_reg = DMA_DST_PTR;
      10:      step_reg = DMA_SRC_INC_D1;
      11:      step_reg = DMA_SRC_INC_D2;
      12:      step_reg = DMA_DST_INC_D1;
      13:      step_reg = DMA_DST_INC_D2;
      14:      step_reg = DMA_SIZE_D2;
      default: step_reg = DMA_SIZE_D1;
    endcase
  endfunction

  function automatic logic [31:0] expected_data(dma_reg_e r);
    longint scale;
    case (cfg.data_type)  // Bytes per element
      DT_HALF: scale = 2;
      DT_BYTE: scale = 1;
      default: scale = 4;
    endcase
    case (r)
      DMA_DIM:        expected_data = 32'd1;
      DMA_SLOTS:      expected_data = cfg.slots;
      DMA_SRC_TYPE,
      DMA_DST_TYPE:   expected_data = 32'(cfg.data_type);
      DMA_TOP_PAD:    expected_data = 32'((cur_txn.pad_top * scale) % 64);
      DMA_BOTTOM_PAD: expected_data = 32'((cur_txn.pad_bottom * scale) % 64);
      DMA_LEFT_PAD:   expected_data = 32'((cur_txn.pad_left * scale) % 64);
      DMA_RIGHT_PAD:  expected_data = 32'((cur_txn.pad_right * scale) % 64);
      DMA_SRC_PTR:    expected_data = cur_txn.in_ptr;
      DMA_DST_PTR:    expected_data = cur_txn.out_ptr;
      DMA_SRC_INC_D1: expected_data = 32'(((longint'(1) << cfg.log_stride_d1) * scale) % 64);
      DMA_SRC_INC_D2: expected_data = 32'((cur_txn.src_inc_d2 * scale) % (longint'(1) << 23));
      DMA_DST_INC_D1,
      DMA_DST_INC_D2: expected_data = 32'(scale);
      DMA_SIZE_D2:    expected_data = 32'((cur_txn.size_d2 * scale) % 65536);
      DMA_SIZE_D1:    expected_data = 32'((cur_txn.size_d1 * scale) % 65536);
      default:        expected_data = '0;
    endcase
  endfunction

  function automatic int lowest_free();
    for (int c = 0; c < DMA_CH_NUM; c++) begin
      if (cfg.ch_mask[c] && !occ[c]) return c;
    end
    return -1;
  endfunction

  function automatic im2col_txn_t random_txn(logic last);
    im2col_txn_t t;
    t.in_ptr     = $random(seed);
    t.out_ptr    = $random(seed);
    t.pad_top    = 8'($random(seed));
    t.pad_bottom = 8'($random(seed));
    t.pad_left   = 8'($random(seed));
    t.pad_right  = 8'($random(seed));
    t.src_inc_d2 = 23'($random(seed));
    t.size_d1    = 16'($random(seed));
    t.size_d2    = 16'($random(seed));
    t.last       = last;
    return t;
  endfunction

  // Runs at a falling edge to check the request and drive ready for the next edge
  task automatic watch_bus();
    dma_reg_req_t exp;
    dma_reg_e     r;
    if (prev_stall) check_req(bus_req, prev_req, "request held during stall");
    if (bus_req.valid && !in_txn) begin
      if (exp_q.size() == 0) report_error("bus write with no transaction queued");
      cur_txn = exp_q.pop_front();
      cur_ch  = lowest_free();  // Occupancy as seen at the claim edge
      if (cur_ch < 0) report_error("bus write while no channel is free");
      step         = used[cur_ch] ? 4 : 0;  // Reuse starts at top pad
      occ[cur_ch]  = 1'b1;
      used[cur_ch] = 1'b1;
      in_txn       = 1'b1;
    end else if (!bus_req.valid && in_txn) begin
      report_error("valid dropped inside a transaction");
    end
    if (bus_req.valid) begin
      r         = step_reg(step);
      exp.valid = 1'b1;
      exp.addr  = DMA_BASE_ADDR + 32'(cur_ch) * DMA_CH_SIZE + 32'(r);
      exp.wdata = expected_data(r);
      if (r == DMA_SRC_TYPE || r == DMA_DST_TYPE) begin
        check_type(data_type_e'(bus_req.wdata[1:0]), cfg.data_type, "data type write");
      end
      check_req(bus_req, exp, $sformatf("channel %0d write %0d", cur_ch, step));
    end
    bus_ready  = (stall_cnt >= MAX_STALL) || (($unsigned($random(seed)) % 4) != 0);
    stall_cnt  = bus_ready ? 0 : stall_cnt + 1;
    prev_stall = bus_req.valid && !bus_ready;
    prev_req   = bus_req;
    if (bus_req.valid && bus_ready) begin
      step++;
      if (step == 16) begin
        in_txn           = 1'b0;
        done_cnt[cur_ch] = 2 + ($unsigned($random(seed)) % MAX_DONE_DLY);
        if (cur_txn.last) loaded_pend = 1'b1;
      end
    end
  endtask

  task automatic drive_dma_done();
    logic [DMA_CH_NUM-1:0] pulse;
    pulse = '0;
    for (int c = 0; c < DMA_CH_NUM; c++) begin
      if (done_cnt[c] > 0) begin
        done_cnt[c]--;
        if (done_cnt[c] == 0) pulse[c] = 1'b1;
      end
    end
    dma_done  = pulse;
    done_prev = pulse;
  endtask

  task automatic run_batch();
    int   n_txn;
    int   pushed;
    logic finished;
    n_txn             = 1 + ($unsigned($random(seed)) % MAX_TXN);
    cfg.data_type     = data_type_e'(2'($unsigned($random(seed)) % 3));
    cfg.log_stride_d1 = 4'($random(seed));
    cfg.slots         = $random(seed);
    cfg.irq_en        = 1'($random(seed));
    do begin
      cfg.ch_mask = DMA_CH_NUM'($random(seed));
    end while (cfg.ch_mask == '0);
    start       = 1'b1;
    occ         = '0;
    used        = '0;
    done_prev   = '0;
    loaded      = 1'b0;
    loaded_pend = 1'b0;
    in_txn      = 1'b0;
    prev_stall  = 1'b0;
    stall_cnt   = 0;
    pushed      = 0;
    finished    = 1'b0;
    for (int c = 0; c < DMA_CH_NUM; c++) done_cnt[c] = 0;
    while (!finished) begin
      @(negedge clk);
      start = 1'b0;
      check_bit(busy, 1'b1, "busy during batch");
      check_bit(irq, 1'b0, "interrupt during batch");
      // Queue holds the unstarted entries plus the one being programmed
      check_bit(txn_full, (exp_q.size() + int'(in_txn)) == FIFO_DEPTH, "queue full flag");
      watch_bus();
      occ = occ & ~done_prev;  // Completions seen at the last edge
      if (loaded_pend) begin
        loaded      = 1'b1;
        loaded_pend = 1'b0;
      end
      finished = loaded && (occ == '0);
      drive_dma_done();
      if (pushed < n_txn && !txn_full && ($random(seed) & 1)) begin
        txn      = random_txn(pushed == n_txn - 1);
        txn_push = 1'b1;
        exp_q.push_back(txn);
        pushed++;
      end else begin
        txn_push = 1'b0;
      end
    end
    @(negedge clk);
    check_bit(busy, 1'b0, "busy after batch end");
    check_bit(irq, cfg.irq_en, "interrupt after batch end");
    if (cfg.irq_en) begin
      repeat (3) begin
        @(negedge clk);
        check_bit(irq, 1'b1, "interrupt held until clear");
      end
      irq_clear = 1'b1;
      @(negedge clk);
      irq_clear = 1'b0;
      check_bit(irq, 1'b0, "interrupt after clear");
    end
  endtask

  initial begin
    seed      = 32'hbd1a1de9;
    rst_n     = 1'b0;
    cfg       = '0;
    start     = 1'b0;
    txn       = '0;
    txn_push  = 1'b0;
    bus_ready = 1'b0;
    dma_done  = '0;
    irq_clear = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit(bus_req.valid, 1'b0, "bus valid after reset");
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(irq, 1'b0, "interrupt after reset");
    for (int b = 0; b < N_BATCH; b++) begin
      run_batch();
    end
    $display("Test passed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYC + 20) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Test failed");
    $fatal(1);
  end

endmodule

/* compile.f */
im2col_pkg.sv
im2col_txn_fifo.sv
im2col_channel_tracker.sv
im2col_dma_loader.sv
im2col_completion.sv
im2col_spc_top.sv
tb_im2col_spc.sv
